//--- design/addrgen_pkg.sv
// Vector address generator package
// Widths, constants, enums and the load/store request struct shared by the design

package addrgen_pkg;

  ////////////////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////////////////

  // AXI address width
  localparam int unsigned AddrWidth = 32;
  // Bytes per data beat and its log
  localparam int unsigned DataBytes = 8;
  localparam int unsigned DataBytesLog = 3;
  // Address bits inside one 4 KiB page
  localparam int unsigned PageBits = 12;
  // AXI4 INCR bursts are limited to 256 beats
  localparam int unsigned MaxBurstBeats = 256;
  // Vector length width
  localparam int unsigned VlWidth = 16;
  // Entries in the load/store request queue
  localparam int unsigned QueueDepth = 4;

  ////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [VlWidth-1:0] vl_t;

  // Element width, encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8 = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Vector memory instruction kind
  typedef enum logic [1:0] {
    OP_VLE = 2'd0,   // unit-stride load
    OP_VSE = 2'd1,   // unit-stride store
    OP_VLSE = 2'd2,  // strided load
    OP_VSSE = 2'd3   // strided store
  } mem_op_e;

  // AXI burst length minus one
  typedef logic [7:0] axlen_t;
  // AXI beat size as log2 of bytes
  typedef logic [2:0] axsize_t;

  // One issued request as seen by the load/store units
  typedef struct packed {
    addr_t addr;
    axlen_t len;
    axsize_t size;
    logic is_load;
  } lsu_req_t;

endpackage

//--- design/mem_req_if.sv
// Decoded memory request channel
// Carries one vector request from the instruction control to the AXI request generator

`timescale 1ns/1ps

interface mem_req_if;

  // Handshake
  logic valid;
  logic ready;

  // Request fields
  addrgen_pkg::addr_t addr;
  addrgen_pkg::vl_t len;
  addrgen_pkg::addr_t stride;
  addrgen_pkg::vew_e vew;
  logic is_load;
  // Unit-stride requests become INCR bursts
  logic is_burst;

  // Pulses with the handshake of the last beat or burst
  logic done;

  // Instruction control side
  modport ctrl (
    output valid, addr, len, stride, vew, is_load, is_burst,
    input ready, done
  );

  // Request generator side
  modport gen (
    input valid, addr, len, stride, vew, is_load, is_burst,
    output ready, done
  );

endinterface

//--- design/insn_ctrl.sv
// Vector memory instruction control
// Accepts one instruction, checks base alignment, hands the request on and acknowledges

`timescale 1ns/1ps

module insn_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Instruction side
  input  logic                  insn_valid_i,
  output logic                  insn_ready_o,
  input  addrgen_pkg::mem_op_e  insn_op_i,
  input  addrgen_pkg::addr_t    insn_addr_i,
  input  addrgen_pkg::vl_t      insn_vl_i,
  input  addrgen_pkg::addr_t    insn_stride_i,
  input  addrgen_pkg::vew_e     insn_vew_i,
  output logic                  ack_o,
  output logic                  exception_o,
  // Request towards the generator
  mem_req_if.ctrl               mem_req_o
);

  // IDLE waits for an instruction, CHECK tests alignment, BUSY waits for done
  enum logic [1:0] {
    IDLE,
    CHECK,
    BUSY
  } state_q, state_d;

  // Registered instruction
  addrgen_pkg::mem_op_e op_q;
  addrgen_pkg::addr_t addr_q;
  addrgen_pkg::vl_t vl_q;
  addrgen_pkg::addr_t stride_q;
  addrgen_pkg::vew_e vew_q;

  // Delayed completion ack
  logic done_ack_q, done_ack_d;

  logic accept;
  logic misaligned;

  assign insn_ready_o = (state_q == IDLE);
  assign accept = insn_valid_i && insn_ready_o;

  // Base address must be a multiple of the element size
  assign misaligned = |(addr_q & ((addrgen_pkg::addr_t'(1) << vew_q) - addrgen_pkg::addr_t'(1)));

  // Misaligned instructions are acknowledged straight from CHECK
  assign exception_o = (state_q == CHECK) && misaligned;
  assign ack_o = exception_o || done_ack_q;

  ////////////////////////////////////////////////////////////////////////
  // Request fields
  ////////////////////////////////////////////////////////////////////////

  assign mem_req_o.valid = (state_q == BUSY);
  assign mem_req_o.addr = addr_q;
  assign mem_req_o.len = vl_q;
  assign mem_req_o.stride = stride_q;
  assign mem_req_o.vew = vew_q;
  assign mem_req_o.is_load = (op_q == addrgen_pkg::OP_VLE) || (op_q == addrgen_pkg::OP_VLSE);
  assign mem_req_o.is_burst = (op_q == addrgen_pkg::OP_VLE) || (op_q == addrgen_pkg::OP_VSE);

  ////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    done_ack_d = 1'b0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        // Misaligned base ends here with the exception ack
        state_d = misaligned ? IDLE : BUSY;
      end
      BUSY: begin
        // Request completes with the generator's done pulse
        if (mem_req_o.done) begin
          state_d = IDLE;
          done_ack_d = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_ack_q <= 1'b0;
    end else begin
      state_q <= state_d;
      done_ack_q <= done_ack_d;
    end
  end

  // Instruction payload, loaded on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= insn_op_i;
      addr_q <= insn_addr_i;
      vl_q <= insn_vl_i;
      stride_q <= insn_stride_i;
      vew_q <= insn_vew_i;
    end
  end

endmodule

//--- design/axi_req_gen.sv
// AXI address request generator
// Splits unit-stride requests into page-bounded INCR bursts and strided ones into single beats

`timescale 1ns/1ps

module axi_req_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Request from the instruction control
  mem_req_if.gen                 mem_req_i,
  // AR channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output addrgen_pkg::addr_t     ar_addr_o,
  output addrgen_pkg::axlen_t    ar_len_o,
  output addrgen_pkg::axsize_t   ar_size_o,
  // AW channel
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output addrgen_pkg::addr_t     aw_addr_o,
  output addrgen_pkg::axlen_t    aw_len_o,
  output addrgen_pkg::axsize_t   aw_size_o,
  // Load/store request queue
  output logic                   q_push_o,
  output addrgen_pkg::lsu_req_t  q_req_o,
  input  logic                   q_full_i,
  input  logic                   q_empty_i,
  input  logic                   q_head_is_load_i
);

  // IDLE takes a request, SETUP computes the first burst end, REQUESTING issues
  enum logic [1:0] {
    IDLE,
    SETUP,
    REQUESTING
  } state_q, state_d;

  // Request being processed
  addrgen_pkg::addr_t cur_addr_q;
  addrgen_pkg::addr_t stride_q;
  addrgen_pkg::vl_t count_q;
  addrgen_pkg::vew_e vew_q;
  logic is_load_q;
  logic is_burst_q;

  // Burst window, all aligned to a data word
  addrgen_pkg::addr_t aligned_start_q;
  addrgen_pkg::addr_t aligned_end_q;
  addrgen_pkg::addr_t next_start_q;
  // Word holding the last covered byte
  addrgen_pkg::addr_t last_word_q;

  addrgen_pkg::addr_t word_mask;
  addrgen_pkg::addr_t base_start;
  addrgen_pkg::addr_t base_end;
  addrgen_pkg::axlen_t burst_len;
  addrgen_pkg::axlen_t ax_len;
  addrgen_pkg::axsize_t ax_size;
  logic ax_ready;
  logic order_ok;
  logic ax_valid;
  logic ax_fire;
  logic last_ax;
  logic accept;

  // Last word of a burst starting at an aligned address
  // Clipped to the page end, to MaxBurstBeats and to the end of the data
  function automatic addrgen_pkg::addr_t burst_end(addrgen_pkg::addr_t start,
                                                   addrgen_pkg::addr_t last_word);
    int unsigned start_off;
    int unsigned beat_off;
    int unsigned end_off;
    start_off = start[addrgen_pkg::PageBits-1:0];
    end_off = (1 << addrgen_pkg::PageBits) - addrgen_pkg::DataBytes;
    beat_off = start_off + (addrgen_pkg::MaxBurstBeats - 1) * addrgen_pkg::DataBytes;
    if (beat_off < end_off) begin
      end_off = beat_off;
    end
    // Data end only counts when it lies in the same page
    if ((last_word[addrgen_pkg::AddrWidth-1:addrgen_pkg::PageBits] ==
         start[addrgen_pkg::AddrWidth-1:addrgen_pkg::PageBits]) &&
        (last_word[addrgen_pkg::PageBits-1:0] < end_off)) begin
      end_off = last_word[addrgen_pkg::PageBits-1:0];
    end
    return {start[addrgen_pkg::AddrWidth-1:addrgen_pkg::PageBits],
            end_off[addrgen_pkg::PageBits-1:0]};
  endfunction

  assign word_mask = ~addrgen_pkg::addr_t'(addrgen_pkg::DataBytes - 1);

  // SETUP starts from the request address, later bursts from the next aligned word
  assign base_start = (state_q == SETUP) ? (cur_addr_q & word_mask) : next_start_q;
  assign base_end = burst_end(base_start, last_word_q);

  ////////////////////////////////////////////////////////////////////////
  // AX request
  ////////////////////////////////////////////////////////////////////////

  assign burst_len = addrgen_pkg::axlen_t'(
      (aligned_end_q[addrgen_pkg::PageBits-1:0] - aligned_start_q[addrgen_pkg::PageBits-1:0])
      >> addrgen_pkg::DataBytesLog);

  assign ax_len = is_burst_q ? burst_len : '0;
  assign ax_size = is_burst_q ? addrgen_pkg::axsize_t'(addrgen_pkg::DataBytesLog)
                              : addrgen_pkg::axsize_t'(vew_q);

  // Do not switch direction while the queue holds requests of the other kind
  assign order_ok = q_empty_i || (q_head_is_load_i == is_load_q);

  // The push is the AX handshake, so valid needs room in the queue
  assign ax_valid = (state_q == REQUESTING) && !q_full_i && order_ok;
  assign ax_ready = is_load_q ? ar_ready_i : aw_ready_i;
  assign ax_fire = ax_valid && ax_ready;

  assign last_ax = is_burst_q ? (aligned_end_q == last_word_q)
                              : (count_q == addrgen_pkg::vl_t'(1));

  assign ar_valid_o = ax_valid && is_load_q;
  assign ar_addr_o = cur_addr_q;
  assign ar_len_o = ax_len;
  assign ar_size_o = ax_size;

  assign aw_valid_o = ax_valid && !is_load_q;
  assign aw_addr_o = cur_addr_q;
  assign aw_len_o = ax_len;
  assign aw_size_o = ax_size;

  // Every issued request goes to the load/store units as well
  assign q_push_o = ax_fire;
  assign q_req_o = '{addr: cur_addr_q, len: ax_len, size: ax_size, is_load: is_load_q};

  assign mem_req_i.ready = (state_q == IDLE);
  assign mem_req_i.done = ax_fire && last_ax;
  assign accept = mem_req_i.valid && mem_req_i.ready;

  ////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = SETUP;
        end
      end
      SETUP: state_d = REQUESTING;
      REQUESTING: begin
        if (mem_req_i.done) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and burst window payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_addr_q <= mem_req_i.addr;
      stride_q <= mem_req_i.stride;
      count_q <= mem_req_i.len;
      vew_q <= mem_req_i.vew;
      is_load_q <= mem_req_i.is_load;
      is_burst_q <= mem_req_i.is_burst;
      // Last covered byte is addr + (len << vew) - 1
      last_word_q <= (mem_req_i.addr + (addrgen_pkg::addr_t'(mem_req_i.len) << mem_req_i.vew)
                      - addrgen_pkg::addr_t'(1)) & word_mask;
    end
    if (state_q == SETUP || (ax_fire && is_burst_q)) begin
      aligned_start_q <= base_start;
      aligned_end_q <= base_end;
      next_start_q <= base_end + addrgen_pkg::addr_t'(addrgen_pkg::DataBytes);
    end
    if (ax_fire) begin
      if (is_burst_q) begin
        // Next burst starts at the following aligned word
        cur_addr_q <= next_start_q;
      end else begin
        cur_addr_q <= cur_addr_q + stride_q;
        count_q <= count_q - addrgen_pkg::vl_t'(1);
      end
    end
  end

endmodule

//--- design/lsu_req_queue.sv
// Load/store request queue
// Circular FIFO of issued AX requests, exposes the direction of its head entry

`timescale 1ns/1ps

module lsu_req_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Push side, from the request generator
  input  logic                   push_i,
  input  addrgen_pkg::lsu_req_t  req_i,
  output logic                   full_o,
  output logic                   empty_o,
  output logic                   head_is_load_o,
  // Pop side, towards the load/store units
  output logic                   lsu_valid_o,
  input  logic                   lsu_ready_i,
  output addrgen_pkg::lsu_req_t  lsu_req_o
);

  localparam int unsigned PtrWidth = $clog2(addrgen_pkg::QueueDepth);

  // Storage
  addrgen_pkg::lsu_req_t mem_q [addrgen_pkg::QueueDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth:0] count_q;
  logic pop;

  assign full_o = (count_q == addrgen_pkg::QueueDepth);
  assign empty_o = (count_q == '0);
  assign lsu_valid_o = !empty_o;
  assign pop = lsu_valid_o && lsu_ready_i;

  // Head entry
  assign lsu_req_o = mem_q[rd_ptr_q];
  assign head_is_load_o = mem_q[rd_ptr_q].is_load;

  ////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(addrgen_pkg::QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(addrgen_pkg::QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

endmodule

//--- design/addrgen_top.sv
// Vector memory address generator top level
// Instruction control, AXI AR/AW request generator and load/store request queue

`timescale 1ns/1ps

module addrgen_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction side
  input  logic                   insn_valid_i,
  output logic                   insn_ready_o,
  input  addrgen_pkg::mem_op_e   insn_op_i,
  input  addrgen_pkg::addr_t     insn_addr_i,
  input  addrgen_pkg::vl_t       insn_vl_i,
  input  addrgen_pkg::addr_t     insn_stride_i,
  input  addrgen_pkg::vew_e      insn_vew_i,
  output logic                   ack_o,
  output logic                   exception_o,
  // AR channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output addrgen_pkg::addr_t     ar_addr_o,
  output addrgen_pkg::axlen_t    ar_len_o,
  output addrgen_pkg::axsize_t   ar_size_o,
  // AW channel
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output addrgen_pkg::addr_t     aw_addr_o,
  output addrgen_pkg::axlen_t    aw_len_o,
  output addrgen_pkg::axsize_t   aw_size_o,
  // Queue output to the load/store units
  output logic                   lsu_valid_o,
  input  logic                   lsu_ready_i,
  output addrgen_pkg::lsu_req_t  lsu_req_o
);

  // Decoded request between control and generator
  mem_req_if mem_req ();

  // Generator to queue
  logic q_push;
  addrgen_pkg::lsu_req_t q_req;
  logic q_full;
  logic q_empty;
  logic q_head_is_load;

  insn_ctrl i_insn_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .insn_op_i     (insn_op_i),
    .insn_addr_i   (insn_addr_i),
    .insn_vl_i     (insn_vl_i),
    .insn_stride_i (insn_stride_i),
    .insn_vew_i    (insn_vew_i),
    .ack_o         (ack_o),
    .exception_o   (exception_o),
    .mem_req_o     (mem_req.ctrl)
  );

  axi_req_gen i_axi_req_gen (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .mem_req_i        (mem_req.gen),
    .ar_valid_o       (ar_valid_o),
    .ar_ready_i       (ar_ready_i),
    .ar_addr_o        (ar_addr_o),
    .ar_len_o         (ar_len_o),
    .ar_size_o        (ar_size_o),
    .aw_valid_o       (aw_valid_o),
    .aw_ready_i       (aw_ready_i),
    .aw_addr_o        (aw_addr_o),
    .aw_len_o         (aw_len_o),
    .aw_size_o        (aw_size_o),
    .q_push_o         (q_push),
    .q_req_o          (q_req),
    .q_full_i         (q_full),
    .q_empty_i        (q_empty),
    .q_head_is_load_i (q_head_is_load)
  );

  lsu_req_queue i_lsu_req_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (q_push),
    .req_i          (q_req),
    .full_o         (q_full),
    .empty_o        (q_empty),
    .head_is_load_o (q_head_is_load),
    .lsu_valid_o    (lsu_valid_o),
    .lsu_ready_i    (lsu_ready_i),
    .lsu_req_o      (lsu_req_o)
  );

endmodule

//--- bench/addrgen_asserts.sv
// Protocol assertions for the vector address generator
// Bound to the top level, AX stability, channel exclusion, ack pulse and reset

`timescale 1ns/1ps

module addrgen_asserts (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  ack_o,
  input logic                  ar_valid_o,
  input logic                  ar_ready_i,
  input addrgen_pkg::addr_t    ar_addr_o,
  input addrgen_pkg::axlen_t   ar_len_o,
  input addrgen_pkg::axsize_t  ar_size_o,
  input logic                  aw_valid_o,
  input logic                  aw_ready_i,
  input addrgen_pkg::addr_t    aw_addr_o,
  input addrgen_pkg::axlen_t   aw_len_o,
  input addrgen_pkg::axsize_t  aw_size_o,
  input logic                  lsu_valid_o
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // AR valid and payload hold until ready
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) &&
                                    $stable(ar_len_o) && $stable(ar_size_o))
    else begin
      $error("AR valid or payload changed before ready");
      fail_count++;
    end

  // Same for AW
  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) &&
                                    $stable(aw_len_o) && $stable(aw_size_o))
    else begin
      $error("AW valid or payload changed before ready");
      fail_count++;
    end

  // One direction at a time
  ax_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(ar_valid_o && aw_valid_o))
    else begin
      $error("AR and AW valid in the same cycle");
      fail_count++;
    end

  // Ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ack_o |=> !ack_o)
    else begin
      $error("ack_o high for two cycles in a row");
      fail_count++;
    end

  // Quiet outputs while in reset
  reset_quiet: assert property (@(posedge clk_i)
      !rst_ni |-> !ar_valid_o && !aw_valid_o && !lsu_valid_o)
    else begin
      $error("valid output high during reset");
      fail_count++;
    end

endmodule

bind addrgen_top addrgen_asserts i_asserts (.*);

//--- bench/tb_addrgen.sv
// Testbench for the vector memory address generator
// Drives instructions, models the expected AX and LSU requests and compares them

`timescale 1ns/1ps

module tb_addrgen;

  //////////////////////////////////////////////////////////////////////
  // Setup
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ResetCycles = 16;
  localparam int unsigned CyclesPerBeat = 200;
  localparam int unsigned HoldCycles = 20;

  typedef addrgen_pkg::lsu_req_t req_queue_t[$];

  // One vector memory instruction
  typedef struct packed {
    addrgen_pkg::mem_op_e op;
    addrgen_pkg::addr_t addr;
    addrgen_pkg::vl_t vl;
    addrgen_pkg::addr_t stride;
    addrgen_pkg::vew_e vew;
  } insn_t;

  // DUT inputs, all with a defined start value
  logic clk_i = 1'b0;
  logic rst_ni = 1'b1;
  logic insn_valid_i = 1'b0;
  addrgen_pkg::mem_op_e insn_op_i = addrgen_pkg::OP_VLE;
  addrgen_pkg::addr_t insn_addr_i = '0;
  addrgen_pkg::vl_t insn_vl_i = '0;
  addrgen_pkg::addr_t insn_stride_i = '0;
  addrgen_pkg::vew_e insn_vew_i = addrgen_pkg::EW8;
  logic ar_ready_i = 1'b0;
  logic aw_ready_i = 1'b0;
  logic lsu_ready_i = 1'b0;

  // DUT outputs
  logic insn_ready_o;
  logic ack_o;
  logic exception_o;
  logic ar_valid_o;
  addrgen_pkg::addr_t ar_addr_o;
  addrgen_pkg::axlen_t ar_len_o;
  addrgen_pkg::axsize_t ar_size_o;
  logic aw_valid_o;
  addrgen_pkg::addr_t aw_addr_o;
  addrgen_pkg::axlen_t aw_len_o;
  addrgen_pkg::axsize_t aw_size_o;
  logic lsu_valid_o;
  addrgen_pkg::lsu_req_t lsu_req_o;

  integer seed = 32'h3f2c;
  // Keeps lsu_ready_i low for the ordering test
  logic lsu_hold = 1'b0;

  // Expected AX requests and queue outputs, in issue order
  req_queue_t exp_ax_q;
  req_queue_t exp_lsu_q;
  // Entries of each direction currently in the DUT queue
  int pending_loads = 0;
  int pending_stores = 0;

  // Test instructions
  insn_t tests [9] = '{
    // Aligned load, one burst
    '{addrgen_pkg::OP_VLE, 32'h1000_0100, 16'd16, 32'h0, addrgen_pkg::EW32},
    // Store across a page and past 256 beats
    '{addrgen_pkg::OP_VSE, 32'h0000_1808, 16'd700, 32'h0, addrgen_pkg::EW64},
    // Unaligned start right before a page end
    '{addrgen_pkg::OP_VLE, 32'h0000_3ffa, 16'd10, 32'h0, addrgen_pkg::EW16},
    // Strided load and strided store with negative stride
    '{addrgen_pkg::OP_VLSE, 32'h0000_0200, 16'd5, 32'h44, addrgen_pkg::EW32},
    '{addrgen_pkg::OP_VSSE, 32'h8000_0010, 16'd4, 32'hffff_fff0, addrgen_pkg::EW16},
    // Misaligned bases
    '{addrgen_pkg::OP_VLE, 32'h0000_1002, 16'd4, 32'h0, addrgen_pkg::EW32},
    '{addrgen_pkg::OP_VSSE, 32'h0000_0011, 16'd3, 32'h2, addrgen_pkg::EW16},
    // Ordering pair, two load bursts then a store
    '{addrgen_pkg::OP_VLE, 32'h0000_1ff0, 16'd8, 32'h0, addrgen_pkg::EW64},
    '{addrgen_pkg::OP_VSE, 32'h0000_5000, 16'd4, 32'h0, addrgen_pkg::EW64}
  };

  addrgen_top dut0 (.*);

  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Base must be a multiple of the element size
  function automatic logic base_misaligned(input insn_t insn);
    return (insn.addr % (32'd1 << insn.vew)) != 32'd0;
  endfunction

  function automatic req_queue_t expected_bursts(input insn_t insn);
    req_queue_t reqs;
    logic is_load;
    int unsigned k;
    addrgen_pkg::addr_t cur;
    addrgen_pkg::addr_t start;
    addrgen_pkg::addr_t stop;
    addrgen_pkg::addr_t last_word;
    addrgen_pkg::addr_t limit;
    is_load = (insn.op == addrgen_pkg::OP_VLE) || (insn.op == addrgen_pkg::OP_VLSE);
    if (base_misaligned(insn)) begin
      return reqs;
    end
    if (insn.op == addrgen_pkg::OP_VLE || insn.op == addrgen_pkg::OP_VSE) begin
      cur = insn.addr;
      // Word holding the last covered byte
      last_word = (insn.addr + (addrgen_pkg::addr_t'(insn.vl) << insn.vew) - 32'd1) & ~32'd7;
      do begin
        start = cur & ~32'd7;
        // Earliest of page end, 256 beats and data end
        stop = start | ((32'd1 << addrgen_pkg::PageBits) - 32'd8);
        limit = start + (addrgen_pkg::MaxBurstBeats - 1) * 8;
        if (limit < stop) begin
          stop = limit;
        end
        if (last_word < stop) begin
          stop = last_word;
        end
        reqs.push_back('{addr: cur, len: addrgen_pkg::axlen_t'((stop - start) >> 3),
                         size: 3'd3, is_load: is_load});
        cur = stop + 32'd8;
      end while (stop != last_word);
    end else begin
      for (k = 0; k < insn.vl; k++) begin
        reqs.push_back('{addr: insn.addr + insn.stride * k, len: 8'd0,
                         size: addrgen_pkg::axsize_t'(insn.vew), is_load: is_load});
      end
    end
    return reqs;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_lsu_req(input string name, input addrgen_pkg::lsu_req_t got,
                               input addrgen_pkg::lsu_req_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = addr %h len %0d size %0d load %b, %s%h len %0d size %0d load %b",
               $time, name, got.addr, got.len, got.size, got.is_load,
               "expected addr ", exp.addr, exp.len, exp.size, exp.is_load);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Random ready inputs, one draw per cycle
  always @(negedge clk_i) begin : drive_readies
    int r;
    r = $random(seed);
    ar_ready_i = r[0] | r[1];
    aw_ready_i = r[2] | r[3];
    lsu_ready_i = !lsu_hold && (r[4] | r[5]);
  end

  task automatic wait_drained();
    while (exp_lsu_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // Issue one instruction and follow it up to its ack
  task automatic run_insn(input insn_t insn);
    req_queue_t reqs;
    logic exp_exc;
    exp_exc = base_misaligned(insn);
    reqs = expected_bursts(insn);
    foreach (reqs[k]) begin
      exp_ax_q.push_back(reqs[k]);
      exp_lsu_q.push_back(reqs[k]);
    end
    @(negedge clk_i);
    insn_valid_i = 1'b1;
    insn_op_i = insn.op;
    insn_addr_i = insn.addr;
    insn_vl_i = insn.vl;
    insn_stride_i = insn.stride;
    insn_vew_i = insn.vew;
    #1;
    while (!insn_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    // Accepted at the posedge in between
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    #1;
    // Busy with the accepted instruction
    check_bit("insn_ready_o", insn_ready_o, 1'b0);
    if (exp_exc) begin
      check_bit("ack_o", ack_o, 1'b1);
      check_bit("exception_o", exception_o, 1'b1);
    end else begin
      while (!ack_o) begin
        @(negedge clk_i);
        #1;
      end
      check_bit("exception_o", exception_o, 1'b0);
      if (exp_ax_q.size() != 0) begin
        report_error("ack_o came before all AX requests were issued");
      end
    end
    @(negedge clk_i);
    #1;
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("exception_o", exception_o, 1'b0);
  endtask

  initial begin : stimulus
    #1 rst_ni = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    // Idle and quiet right after reset
    check_bit("insn_ready_o", insn_ready_o, 1'b1);
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("exception_o", exception_o, 1'b0);
    // Unit-stride, strided and misaligned cases
    for (int i = 0; i < 7; i++) begin
      // No queue traffic may be left when an exception is expected
      if (base_misaligned(tests[i])) begin
        wait_drained();
      end
      run_insn(tests[i]);
    end
    wait_drained();
    // Store behind loads stuck in the queue
    @(posedge clk_i);
    lsu_hold = 1'b1;
    run_insn(tests[7]);
    fork
      run_insn(tests[8]);
      begin
        repeat (HoldCycles) @(posedge clk_i);
        lsu_hold = 1'b0;
      end
    join
    wait_drained();
    repeat (2) @(negedge clk_i);
    if (dut0.i_asserts.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      report_error("a protocol assertion failed");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////

  // Samples in the low phase, where the next posedge handshakes are settled
  always begin : compare_outputs
    addrgen_pkg::lsu_req_t got;
    @(negedge clk_i);
    #1;
    if (rst_ni) begin
      if (dut0.i_asserts.fail_count != 0) begin
        report_error("a protocol assertion failed");
      end
      if ((ar_valid_o || aw_valid_o) && exp_ax_q.size() == 0) begin
        report_error("AX valid raised while no request was expected");
      end
      // Direction switch only with an empty queue
      if (ar_valid_o && pending_stores != 0) begin
        report_error("AR valid while store requests are still queued");
      end
      if (aw_valid_o && pending_loads != 0) begin
        report_error("AW valid while load requests are still queued");
      end
      if (ar_valid_o && ar_ready_i) begin
        got = '{addr: ar_addr_o, len: ar_len_o, size: ar_size_o, is_load: 1'b1};
        check_lsu_req("ar_addr_o/ar_len_o/ar_size_o", got, exp_ax_q.pop_front());
        pending_loads++;
      end
      if (aw_valid_o && aw_ready_i) begin
        got = '{addr: aw_addr_o, len: aw_len_o, size: aw_size_o, is_load: 1'b0};
        check_lsu_req("aw_addr_o/aw_len_o/aw_size_o", got, exp_ax_q.pop_front());
        pending_stores++;
      end
      if (lsu_valid_o && exp_lsu_q.size() == 0) begin
        report_error("lsu_valid_o raised while no request was expected");
      end
      if (lsu_valid_o && lsu_ready_i) begin
        check_lsu_req("lsu_req_o", lsu_req_o, exp_lsu_q.pop_front());
        if (lsu_req_o.is_load) begin
          pending_loads--;
        end else begin
          pending_stores--;
        end
      end
    end
  end

  // Limit from the expected beat count of all tests
  initial begin : watchdog
    req_queue_t reqs;
    int unsigned beats;
    int unsigned limit;
    beats = 0;
    foreach (tests[i]) begin
      reqs = expected_bursts(tests[i]);
      if (reqs.size() == 0) begin
        beats += 1;
      end
      foreach (reqs[k]) begin
        beats += int'(reqs[k].len) + 1;
      end
    end
    limit = ResetCycles + CyclesPerBeat * beats;
    repeat (limit) @(posedge clk_i);
    report_error($sformatf("timeout, run did not finish within %0d cycles", limit));
  end

endmodule

//--- sim.f
design/addrgen_pkg.sv
design/mem_req_if.sv
design/insn_ctrl.sv
design/axi_req_gen.sv
design/lsu_req_queue.sv
design/addrgen_top.sv
bench/addrgen_asserts.sv
bench/tb_addrgen.sv

//--- Bender.yml
package:
  name: addrgen

sources:
  # Design sources in compile order
  - files:
      - design/addrgen_pkg.sv
      - design/mem_req_if.sv
      - design/insn_ctrl.sv
      - design/axi_req_gen.sv
      - design/lsu_req_queue.sv
      - design/addrgen_top.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - bench/addrgen_asserts.sv
      - bench/tb_addrgen.sv
